/* armPkg.sv */
/*
 * Shared types of the single-cycle ARM core: word and field types,
 * instruction field enums, control bundle and flag struct
 */
package armPkg;

   typedef logic [31:0] word_t;     // Data or address word
   typedef logic [3:0]  regAddr_t;  // Register number
   typedef logic [11:0] imm12_t;    // LDR/STR offset
   typedef logic [23:0] imm24_t;    // Branch offset, word units

   // Condition field, Instr[31:28]
   typedef enum logic [3:0] {
      EQ = 4'b0000,
      NE = 4'b0001,
      CS = 4'b0010,
      CC = 4'b0011,
      MI = 4'b0100,
      PL = 4'b0101,
      VS = 4'b0110,
      VC = 4'b0111,
      HI = 4'b1000,
      LS = 4'b1001,
      GE = 4'b1010,
      LT = 4'b1011,
      GT = 4'b1100,
      LE = 4'b1101,
      AL = 4'b1110
   } cond_e;

   // Instruction class, Instr[27:26]
   typedef enum logic [1:0] {
      dataProc = 2'b00,
      memory   = 2'b01,
      branch   = 2'b10
   } opClass_e;

   typedef enum logic [2:0] {
      aluAdd,
      aluSub,
      aluAnd,
      aluOrr,
      aluEor,
      aluMov
   } aluOp_e;

   typedef enum logic [1:0] {
      imm8,   // Data processing, zero extended
      imm12,  // Load/store offset, zero extended
      imm24   // Branch, sign extended and shifted
   } immSrc_e;

   typedef struct packed {
      logic n;
      logic z;
      logic c;
      logic v;
   } flags_t;

   typedef struct packed {
      logic [1:0] regSrc;   // [0] R15 on port 1, [1] Rd on port 2
      immSrc_e    immSrc;
      logic       aluSrc;   // Immediate as second operand
      logic       memToReg;
      logic       regWrite;
      logic       memWrite;
      logic       memAccess;
      logic       pcWrite;  // Branch or write to R15
      aluOp_e     aluOp;
      logic       flagWriteNz;
      logic       flagWriteCv;
      logic       noWrite;  // CMP result discarded
   } ctrl_t;

endpackage

/* armAlu.sv */
/*
 * ALU with add, sub, and, orr, eor and mov, plus N Z C V flags
 */
`timescale 1ns/1ps

module armAlu (
   input  armPkg::word_t  a,
   input  armPkg::word_t  b,
   input  armPkg::aluOp_e op,
   output armPkg::word_t  result,
   output armPkg::flags_t flags
);

   logic          sub;
   logic          isArith;
   armPkg::word_t condInvB;
   logic [32:0]   sum;

   assign sub     = (op == armPkg::aluSub);
   assign isArith = (op == armPkg::aluAdd) || sub;

   // One adder, b inverted plus carry in for subtraction
   assign condInvB = sub ? ~b : b;
   assign sum      = {1'b0, a} + {1'b0, condInvB} + {32'b0, sub};

   always_comb begin
      case (op)
         armPkg::aluAdd: result = sum[31:0];
         armPkg::aluSub: result = sum[31:0];
         armPkg::aluAnd: result = a & b;
         armPkg::aluOrr: result = a | b;
         armPkg::aluEor: result = a ^ b;
         armPkg::aluMov: result = b;
         default:        result = '0;
      endcase
   end

   assign flags.n = result[31];
   assign flags.z = (result == '0);
   assign flags.c = isArith & sum[32];   // Not-borrow on SUB

   // Operands of like sign, result of the other sign
   assign flags.v = isArith & ~(a[31] ^ b[31] ^ sub) & (a[31] ^ sum[31]);

endmodule

/* regFile.sv */
/*
 * Fifteen general registers, two read ports and one write port
 */
`timescale 1ns/1ps

module regFile (
   input  logic             clk,
   input  logic             we,
   input  armPkg::regAddr_t ra1,
   input  armPkg::regAddr_t ra2,
   input  armPkg::regAddr_t wa,
   input  armPkg::word_t    wd,
   input  armPkg::word_t    r15,
   output armPkg::word_t    rd1,
   output armPkg::word_t    rd2
);

   armPkg::word_t regs [0:14];   // R0 to R14

   // R15 lives in the PC, so a write there only moves the PC
   always_ff @(posedge clk) begin
      if (we && wa != 4'hF) begin
         regs[wa] <= wd;
      end
   end

   assign rd1 = (ra1 == 4'hF) ? r15 : regs[ra1];
   assign rd2 = (ra2 == 4'hF) ? r15 : regs[ra2];

endmodule

/* armDecoder.sv */
/*
 * Main and ALU decoder, instruction bits to control bundle
 */
`timescale 1ns/1ps

module armDecoder (
   input  armPkg::word_t instr,
   output armPkg::ctrl_t ctrl
);

   armPkg::opClass_e opClass;
   armPkg::aluOp_e   dpOp;
   armPkg::regAddr_t rd;
   logic [3:0]       funct;
   logic             immBit;  // Operand 2 is imm8
   logic             sBit;
   logic             loadBit; // LDR when set, STR when clear
   logic             dpValid;
   logic             isCmp;
   logic             isArith;

   assign opClass = armPkg::opClass_e'(instr[27:26]);
   assign immBit  = instr[25];
   assign funct   = instr[24:21];
   assign sBit    = instr[20];
   assign loadBit = instr[20];
   assign rd      = instr[15:12];

   // ALU decoder for data processing
   always_comb begin
      dpOp    = armPkg::aluAdd;
      dpValid = 1'b1;
      isCmp   = 1'b0;
      case (funct)
         4'b0100: dpOp = armPkg::aluAdd;
         4'b0010: dpOp = armPkg::aluSub;
         4'b0000: dpOp = armPkg::aluAnd;
         4'b1100: dpOp = armPkg::aluOrr;
         4'b0001: dpOp = armPkg::aluEor;
         4'b1101: dpOp = armPkg::aluMov;
         4'b1010: begin
            dpOp  = armPkg::aluSub; // CMP is a SUB without writeback
            isCmp = 1'b1;
         end
         default: dpValid = 1'b0;  // Unsupported op runs as a no-op
      endcase
   end

   assign isArith = (dpOp == armPkg::aluAdd) || (dpOp == armPkg::aluSub);

   // Main decoder
   always_comb begin
      ctrl        = '0;
      ctrl.immSrc = armPkg::imm8;
      ctrl.aluOp  = armPkg::aluAdd; // Address and target math
      case (opClass)
         armPkg::dataProc: begin
            ctrl.immSrc      = armPkg::imm8;
            ctrl.aluSrc      = immBit;
            ctrl.regWrite    = dpValid;
            ctrl.aluOp       = dpOp;
            ctrl.flagWriteNz = dpValid & (sBit | isCmp);
            ctrl.flagWriteCv = dpValid & (sBit | isCmp) & isArith;
            ctrl.noWrite     = isCmp;
         end
         armPkg::memory: begin
            ctrl.regSrc    = {~loadBit, 1'b0}; // STR reads Rd as data
            ctrl.immSrc    = armPkg::imm12;
            ctrl.aluSrc    = 1'b1;
            ctrl.memToReg  = loadBit;
            ctrl.regWrite  = loadBit;
            ctrl.memWrite  = ~loadBit;
            ctrl.memAccess = 1'b1;
         end
         armPkg::branch: begin
            ctrl.regSrc  = 2'b01;           // Base is PC+8
            ctrl.immSrc  = armPkg::imm24;
            ctrl.aluSrc  = 1'b1;
            ctrl.pcWrite = 1'b1;
         end
         default: ;                         // Class 11 is a no-op
      endcase

      // A result written to R15 is a jump
      if (rd == 4'hF && ctrl.regWrite && !ctrl.noWrite) begin
         ctrl.pcWrite = 1'b1;
      end
   end

endmodule

/* condUnit.sv */
/*
 * Flag registers, condition check and gating of the write enables
 */
`timescale 1ns/1ps

module condUnit (
   input  logic           clk,
   input  logic           reset,
   input  armPkg::cond_e  cond,
   input  armPkg::ctrl_t  ctrl,
   input  armPkg::flags_t aluFlags,
   output logic           regWriteEn,
   output logic           pcSrc,
   output logic           memWrite,
   output logic           memStrobe
);

   armPkg::flags_t flags;
   logic           condEx;
   logic           ge;

   assign ge = (flags.n == flags.v);

   always_comb begin
      case (cond)
         armPkg::EQ: condEx = flags.z;
         armPkg::NE: condEx = ~flags.z;
         armPkg::CS: condEx = flags.c;
         armPkg::CC: condEx = ~flags.c;
         armPkg::MI: condEx = flags.n;
         armPkg::PL: condEx = ~flags.n;
         armPkg::VS: condEx = flags.v;
         armPkg::VC: condEx = ~flags.v;
         armPkg::HI: condEx = flags.c & ~flags.z;
         armPkg::LS: condEx = ~flags.c | flags.z;
         armPkg::GE: condEx = ge;
         armPkg::LT: condEx = ~ge;
         armPkg::GT: condEx = ~flags.z & ge;
         armPkg::LE: condEx = flags.z | ~ge;
         armPkg::AL: condEx = 1'b1;
         default:    condEx = 1'b0; // 1111 never executes
      endcase
   end

   // N/Z and C/V pairs load separately
   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         flags <= '0;
      end else begin
         if (condEx && ctrl.flagWriteNz) begin
            flags.n <= aluFlags.n;
            flags.z <= aluFlags.z;
         end
         if (condEx && ctrl.flagWriteCv) begin
            flags.c <= aluFlags.c;
            flags.v <= aluFlags.v;
         end
      end
   end

   assign regWriteEn = ctrl.regWrite & ~ctrl.noWrite & condEx & ~reset;
   assign pcSrc      = ctrl.pcWrite & condEx & ~reset;
   assign memWrite   = ctrl.memWrite & condEx & ~reset;
   assign memStrobe  = ctrl.memAccess & condEx & ~reset;

endmodule

/* armDatapath.sv */
/*
 * PC register, immediate extension, operand and result muxes
 * Holds the register file and the ALU
 */
`timescale 1ns/1ps

module armDatapath #(
   parameter armPkg::word_t ResetVector = '0
) (
   input  logic           clk,
   input  logic           reset,
   input  armPkg::word_t  instr,
   input  armPkg::ctrl_t  ctrl,
   input  logic           regWriteEn,
   input  logic           pcSrc,
   input  armPkg::word_t  readData,
   output armPkg::word_t  pc,
   output armPkg::word_t  memAddr,
   output armPkg::word_t  memWriteData,
   output armPkg::flags_t aluFlags
);

   armPkg::word_t    pcPlus4;
   armPkg::word_t    pcPlus8;
   armPkg::word_t    pcNext;
   armPkg::word_t    extImm;
   armPkg::word_t    srcA;
   armPkg::word_t    srcB;
   armPkg::word_t    regData2;
   armPkg::word_t    aluResult;
   armPkg::word_t    result;
   armPkg::regAddr_t ra1;
   armPkg::regAddr_t ra2;
   armPkg::imm12_t   memOffset;
   armPkg::imm24_t   branchOffset;

   assign pcPlus4 = pc + 32'd4;
   assign pcPlus8 = pc + 32'd8;   // What R15 reads as
   assign pcNext  = pcSrc ? result : pcPlus4;

   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         pc <= ResetVector;
      end else begin
         pc <= pcNext;
      end
   end

   // Read port addresses
   assign ra1 = ctrl.regSrc[0] ? 4'hF : instr[19:16];
   assign ra2 = ctrl.regSrc[1] ? instr[15:12] : instr[3:0];

   regFile regs (
      .clk(clk),
      .we (regWriteEn),
      .ra1(ra1),
      .ra2(ra2),
      .wa (instr[15:12]),
      .wd (result),
      .r15(pcPlus8),
      .rd1(srcA),
      .rd2(regData2)
   );

   assign memOffset    = instr[11:0];
   assign branchOffset = instr[23:0];

   always_comb begin
      case (ctrl.immSrc)
         armPkg::imm8:  extImm = {24'b0, instr[7:0]};
         armPkg::imm12: extImm = {20'b0, memOffset};
         armPkg::imm24: extImm = {{6{branchOffset[23]}}, branchOffset, 2'b00};
         default:       extImm = '0;
      endcase
   end

   assign srcB = ctrl.aluSrc ? extImm : regData2;

   armAlu alu (
      .a     (srcA),
      .b     (srcB),
      .op    (ctrl.aluOp),
      .result(aluResult),
      .flags (aluFlags)
   );

   assign result       = ctrl.memToReg ? readData : aluResult;
   assign memAddr      = aluResult;
   assign memWriteData = regData2;  // Rd for STR

endmodule

/* armCore.sv */
/*
 * Single-cycle ARMv4 subset core, top level
 * Decoder, condition unit and datapath joined to the memory ports
 */
`timescale 1ns/1ps

module armCore #(
   parameter armPkg::word_t ResetVector = '0
) (
   input  logic          clk,
   input  logic          reset,
   output armPkg::word_t pc,
   input  armPkg::word_t instr,
   output armPkg::word_t memAddr,
   output armPkg::word_t memWriteData,
   output logic          memWrite,
   output logic          memStrobe,
   input  armPkg::word_t readData
);

   armPkg::ctrl_t  ctrl;
   armPkg::flags_t aluFlags;
   logic           regWriteEn;
   logic           pcSrc;

   armDecoder decoder (
      .instr(instr),
      .ctrl (ctrl)
   );

   // Condition field goes straight from the instruction
   condUnit cond (
      .clk       (clk),
      .reset     (reset),
      .cond      (armPkg::cond_e'(instr[31:28])),
      .ctrl      (ctrl),
      .aluFlags  (aluFlags),
      .regWriteEn(regWriteEn),
      .pcSrc     (pcSrc),
      .memWrite  (memWrite),
      .memStrobe (memStrobe)
   );

   armDatapath #(
      .ResetVector(ResetVector)
   ) datapath (
      .clk         (clk),
      .reset       (reset),
      .instr       (instr),
      .ctrl        (ctrl),
      .regWriteEn  (regWriteEn),
      .pcSrc       (pcSrc),
      .readData    (readData),
      .pc          (pc),
      .memAddr     (memAddr),
      .memWriteData(memWriteData),
      .aluFlags    (aluFlags)
   );

endmodule

/* armCore_sva.sv */
/*
 * Bound assertions on the memory strobes and the PC of armCore
 */
`timescale 1ns/1ps

module armCoreProps (
   input logic          clk,
   input logic          reset,
   input armPkg::word_t pc,
   input logic          memWrite,
   input logic          memStrobe
);

   int unsigned assertFails = 0;

   // A store is always a memory access
   writeHasStrobe: assert property (@(posedge clk) disable iff (reset) memWrite |-> memStrobe)
      else begin
         assertFails++;
         $error("memWrite is high while memStrobe is low");
      end

   quietInReset: assert property (@(posedge clk) reset |-> !memStrobe && !memWrite)
      else begin
         assertFails++;
         $error("memory port active during reset");
      end

   pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
      else begin
         assertFails++;
         $error("pc is not word aligned");
      end

endmodule

bind armCore armCoreProps props (
   .clk      (clk),
   .reset    (reset),
   .pc       (pc),
   .memWrite (memWrite),
   .memStrobe(memStrobe)
);

/* armCore_tb.sv */
/*
 * Testbench for armCore with clock, reset, program and data memories,
 * reference model of the instruction subset and per-cycle comparison
 */
`timescale 1ns/1ps

module armCore_tb;

   localparam armPkg::word_t resetVec = 32'h0000_0100;
   localparam int cycleLimit = 3000;
   localparam logic [3:0] condEq = 4'h0;
   localparam logic [3:0] condNe = 4'h1;
   localparam logic [3:0] condAl = 4'hE;
   localparam logic [3:0] opAnd = 4'b0000;
   localparam logic [3:0] opEor = 4'b0001;
   localparam logic [3:0] opSub = 4'b0010;
   localparam logic [3:0] opAdd = 4'b0100;
   localparam logic [3:0] opCmp = 4'b1010;
   localparam logic [3:0] opOrr = 4'b1100;
   localparam logic [3:0] opMov = 4'b1101;
   localparam logic [23:0] aluFuncts = {opAdd, opSub, opAnd, opOrr, opEor, opMov};

   typedef struct packed {
      armPkg::word_t nextPc;
      logic          memWrite;
      logic          memStrobe;
      armPkg::word_t memAddr;
      armPkg::word_t memWriteData;
   } stepResult_t;

   logic          clk;
   logic          reset;
   armPkg::word_t pc;
   armPkg::word_t instr;
   armPkg::word_t memAddr;
   armPkg::word_t memWriteData;
   armPkg::word_t readData;
   logic          memWrite;
   logic          memStrobe;

   armPkg::word_t  prog [0:1023];
   armPkg::word_t  dmem [0:255];
   int             progIdx;
   armPkg::word_t  endAddr;
   int             errors = 0;
   int             checks = 0;

   // Reference model state
   armPkg::word_t  refRegs [0:14];
   armPkg::word_t  refMem [0:255];
   armPkg::word_t  refPc;
   armPkg::flags_t refFlags;
   stepResult_t    expected;

   armCore #(
      .ResetVector(resetVec)
   ) dut (
      .clk         (clk),
      .reset       (reset),
      .pc          (pc),
      .instr       (instr),
      .memAddr     (memAddr),
      .memWriteData(memWriteData),
      .memWrite    (memWrite),
      .memStrobe   (memStrobe),
      .readData    (readData)
   );

   assign instr    = prog[pc[11:2]];      // Same-cycle fetch
   assign readData = dmem[memAddr[9:2]];

   always @(posedge clk) begin
      if (memWrite) begin
         dmem[memAddr[9:2]] <= memWriteData;
      end
   end

   initial begin
      clk = 1'b0;
      forever begin
         #10 clk = ~clk;
      end
   end

   function automatic armPkg::word_t encodeDp(input logic [3:0] cond, input logic [3:0] funct,
         input logic s, input logic imm, input logic [3:0] rn, input logic [3:0] rd,
         input logic [7:0] op2);
      return {cond, 2'b00, imm, funct, s, rn, rd, 4'b0000, op2};
   endfunction

   // Pre-indexed, offset added, no writeback
   function automatic armPkg::word_t encodeMem(input logic [3:0] cond, input logic load,
         input logic [3:0] rn, input logic [3:0] rd, input logic [11:0] offset);
      return {cond, 2'b01, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, load, rn, rd, offset};
   endfunction

   function automatic armPkg::word_t encodeBranch(input logic [3:0] cond,
         input armPkg::word_t from, input armPkg::word_t to);
      armPkg::word_t diff;
      diff = to - from - 32'd8;
      return {cond, 4'b1010, diff[25:2]};
   endfunction

   function automatic logic [11:0] randOffset();
      logic [7:0] w;
      w = 8'($urandom_range(255, 0));
      return {2'b00, w, 2'b00};
   endfunction

   function automatic logic [3:0] randReg();
      return 4'(1 + $urandom_range(7, 0));  // R1 to R8 hold full-width values
   endfunction

   function automatic armPkg::word_t nextAddr();
      return armPkg::word_t'(progIdx) << 2;
   endfunction

   task automatic emit(input armPkg::word_t w);
      prog[progIdx] = w;
      progIdx++;
   endtask

   function automatic logic condPasses(input logic [3:0] cond, input armPkg::flags_t f);
      case (cond)
         4'h0: return f.z;
         4'h1: return !f.z;
         4'h2: return f.c;
         4'h3: return !f.c;
         4'h4: return f.n;
         4'h5: return !f.n;
         4'h6: return f.v;
         4'h7: return !f.v;
         4'h8: return f.c && !f.z;
         4'h9: return !f.c || f.z;
         4'hA: return f.n == f.v;
         4'hB: return f.n != f.v;
         4'hC: return !f.z && (f.n == f.v);
         4'hD: return f.z || (f.n != f.v);
         4'hE: return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   function automatic armPkg::word_t regValue(input logic [3:0] r);
      return (r == 4'hF) ? refPc + 32'd8 : refRegs[r];
   endfunction

   // One instruction of the reference machine, updates its state
   function automatic stepResult_t refStep(input armPkg::word_t ins);
      stepResult_t   res;
      armPkg::word_t a;
      armPkg::word_t b;
      armPkg::word_t val;
      armPkg::word_t addr;
      logic [32:0]   wide;
      logic          arith;
      logic          valid;
      logic          c;
      logic          v;
      res = '0;
      res.nextPc = refPc + 32'd4;
      if (condPasses(ins[31:28], refFlags)) begin
         case (ins[27:26])
            2'b00: begin
               a = regValue(ins[19:16]);
               b = ins[25] ? {24'b0, ins[7:0]} : regValue(ins[3:0]);
               arith = 1'b0;
               valid = 1'b1;
               c = 1'b0;
               v = 1'b0;
               val = '0;
               case (ins[24:21])
                  opAdd: begin
                     wide = {1'b0, a} + {1'b0, b};
                     val = wide[31:0];
                     c = wide[32];
                     v = (a[31] == b[31]) && (val[31] != a[31]);
                     arith = 1'b1;
                  end
                  opSub, opCmp: begin
                     val = a - b;
                     c = (a >= b);               // No borrow
                     v = (a[31] != b[31]) && (val[31] != a[31]);
                     arith = 1'b1;
                  end
                  opAnd: val = a & b;
                  opOrr: val = a | b;
                  opEor: val = a ^ b;
                  opMov: val = b;
                  default: valid = 1'b0;
               endcase
               if (valid && (ins[20] || ins[24:21] == opCmp)) begin
                  refFlags.n = val[31];
                  refFlags.z = (val == 32'd0);
                  if (arith) begin
                     refFlags.c = c;
                     refFlags.v = v;
                  end
               end
               if (valid && ins[24:21] != opCmp) begin
                  if (ins[15:12] == 4'hF) res.nextPc = val;
                  else refRegs[ins[15:12]] = val;
               end
            end
            2'b01: begin
               addr = regValue(ins[19:16]) + {20'b0, ins[11:0]};
               res.memStrobe = 1'b1;
               res.memAddr = addr;
               if (ins[20]) begin
                  if (ins[15:12] == 4'hF) res.nextPc = refMem[addr[9:2]];
                  else refRegs[ins[15:12]] = refMem[addr[9:2]];
               end else begin
                  res.memWrite = 1'b1;
                  res.memWriteData = regValue(ins[15:12]);
                  refMem[addr[9:2]] = res.memWriteData;
               end
            end
            2'b10: res.nextPc = refPc + 32'd8 + {{6{ins[23]}}, ins[23:0], 2'b00};
            default: ;
         endcase
      end
      refPc = res.nextPc;
      return res;
   endfunction

   task automatic noteMismatch(input string name, input armPkg::word_t got,
         input armPkg::word_t want);
      errors++;
      $display("[ERROR] %s: got %h, expected %h at %0t", name, got, want, $time);
   endtask

   task automatic buildProgram();
      armPkg::word_t base;
      logic [11:0]   off;
      logic [3:0]    ra;
      logic [3:0]    rb;
      logic [3:0]    fn;
      int            r;
      int            c;
      for (r = 0; r < 1024; r++) begin
         prog[r] = 32'hEAFF_FFFE;           // Branch to self
      end
      progIdx = resetVec >> 2;
      // Store at the reset vector stays masked during reset
      emit(encodeMem(condAl, 1'b0, 4'hF, 4'hF, 12'h000));
      emit(encodeDp(condAl, opMov, 1'b0, 1'b1, 4'h0, 4'h0, 8'h00));  // R0 is the base
      for (r = 1; r < 15; r++) begin
         emit(encodeDp(condAl, opMov, 1'b0, 1'b1, 4'h0, 4'(r), 8'($urandom_range(255, 0))));
      end
      for (r = 1; r < 9; r++) begin
         emit(encodeMem(condAl, 1'b1, 4'h0, 4'(r), randOffset()));
      end
      // ALU ops in register and immediate form with each result stored
      for (r = 0; r < 3; r++) begin
         for (c = 0; c < 6; c++) begin
            fn = aluFuncts[(5 - c) * 4 +: 4];
            ra = randReg();
            rb = randReg();
            emit(encodeDp(condAl, fn, 1'b0, 1'b0, ra, 4'd9, {4'b0, rb}));
            emit(encodeMem(condAl, 1'b0, 4'h0, 4'd9, randOffset()));
            emit(encodeDp(condAl, fn, 1'b0, 1'b1, ra, 4'd9, 8'($urandom_range(255, 0))));
            emit(encodeMem(condAl, 1'b0, 4'h0, 4'd9, randOffset()));
         end
      end
      // Flag setters followed by all fifteen conditions
      for (r = 0; r < 9; r++) begin
         ra = randReg();
         rb = randReg();
         case (r)
            0: emit(encodeDp(condAl, opCmp, 1'b1, 1'b0, ra, 4'h0, {4'b0, rb}));
            1: emit(encodeDp(condAl, opCmp, 1'b1, 1'b0, ra, 4'h0, {4'b0, ra}));
            2: emit(encodeDp(condAl, opAdd, 1'b1, 1'b0, ra, 4'd13, {4'b0, rb}));
            3: emit(encodeDp(condAl, opSub, 1'b1, 1'b0, ra, 4'd13, {4'b0, rb}));
            4: emit(encodeDp(condAl, opMov, 1'b1, 1'b1, 4'h0, 4'd13, 8'h00));
            5: emit(encodeDp(condAl, opAnd, 1'b1, 1'b0, ra, 4'd13, {4'b0, rb}));
            6: emit(encodeDp(condAl, opCmp, 1'b1, 1'b1, ra, 4'h0, 8'($urandom_range(255, 0))));
            7: emit(encodeDp(condAl, opOrr, 1'b1, 1'b0, ra, 4'd13, {4'b0, rb}));
            default: emit(encodeDp(condAl, opEor, 1'b1, 1'b0, ra, 4'd13, {4'b0, rb}));
         endcase
         for (c = 0; c < 15; c++) begin
            emit(encodeMem(4'(c), 1'b0, 4'h0, randReg(), randOffset()));
            emit(encodeDp(4'(c), opAdd, 1'b0, 1'b1, 4'd10, 4'd10, 8'(c + 1)));
         end
         emit(encodeMem(condAl, 1'b0, 4'h0, 4'd10, randOffset()));
      end
      // Store, reload, store again
      for (r = 0; r < 6; r++) begin
         off = randOffset();
         emit(encodeMem(condAl, 1'b0, 4'h0, randReg(), off));
         emit(encodeMem(condAl, 1'b1, 4'h0, 4'd14, off));
         emit(encodeMem(condAl, 1'b0, 4'h0, 4'd14, randOffset()));
      end
      base = nextAddr();
      emit(encodeBranch(condAl, base, base + 16));       // Forward
      emit(encodeMem(condAl, 1'b0, 4'h0, 4'd4, randOffset()));
      emit(encodeBranch(condAl, base + 8, base + 24));
      emit(encodeMem(condAl, 1'b0, 4'h0, 4'd6, randOffset()));   // Skipped
      emit(encodeBranch(condAl, base + 16, base + 4));   // Backward
      emit(encodeMem(condAl, 1'b0, 4'h0, 4'd7, randOffset()));   // Skipped
      emit(encodeDp(condAl, opCmp, 1'b1, 1'b1, 4'h0, 4'h0, 8'h00));  // Z set
      base = nextAddr();
      emit(encodeBranch(condNe, base, base + 12));       // Not taken
      emit(encodeMem(condAl, 1'b0, 4'h0, 4'd8, randOffset()));
      emit(encodeBranch(condEq, base + 8, base + 16));
      emit(encodeMem(condAl, 1'b0, 4'h0, 4'd9, randOffset()));
      // R15 as source and as destination
      base = nextAddr();
      emit(encodeDp(condAl, opAdd, 1'b0, 1'b1, 4'hF, 4'd12, 8'd12));
      emit(encodeMem(condAl, 1'b0, 4'h0, 4'd12, randOffset()));
      emit(encodeDp(condAl, opMov, 1'b0, 1'b0, 4'h0, 4'hF, 8'd12));
      emit(encodeMem(condAl, 1'b0, 4'h0, 4'd1, randOffset()));
      emit(encodeMem(condAl, 1'b0, 4'h0, 4'd2, randOffset()));
      emit(encodeMem(condAl, 1'b0, 4'h0, 4'hF, randOffset()));   // Stores PC+8
      endAddr = nextAddr();
      emit(encodeBranch(condAl, endAddr, endAddr));
   endtask

   // Compare against the reference once per cycle
   always @(posedge clk) begin
      #5;
      checks++;
      if (reset) begin
         assert (pc === resetVec) else noteMismatch("pc", pc, resetVec);
         assert (memWrite === 1'b0) else noteMismatch("memWrite", memWrite, 32'd0);
         assert (memStrobe === 1'b0) else noteMismatch("memStrobe", memStrobe, 32'd0);
      end else begin
         assert (pc === refPc) else noteMismatch("pc", pc, refPc);
         expected = refStep(instr);
         assert (memWrite === expected.memWrite)
            else noteMismatch("memWrite", memWrite, expected.memWrite);
         assert (memStrobe === expected.memStrobe)
            else noteMismatch("memStrobe", memStrobe, expected.memStrobe);
         if (expected.memStrobe) begin
            assert (memAddr === expected.memAddr)
               else noteMismatch("memAddr", memAddr, expected.memAddr);
         end
         if (expected.memWrite) begin
            assert (memWriteData === expected.memWriteData)
               else noteMismatch("memWriteData", memWriteData, expected.memWriteData);
         end
      end
   end

   initial begin
      int  cycles;
      logic timedOut;
      reset = 1'b1;
      timedOut = 1'b0;
      cycles = 0;
      void'($urandom(94367));
      for (int i = 0; i < 256; i++) begin
         dmem[i] = $urandom;
         refMem[i] = dmem[i];
      end
      for (int i = 0; i < 15; i++) begin
         refRegs[i] = '0;
      end
      refPc = resetVec;
      refFlags = '0;
      buildProgram();
      repeat (5) @(posedge clk);
      #2 reset = 1'b0;
      while (pc !== endAddr && cycles < cycleLimit) begin
         @(negedge clk);
         cycles++;
      end
      if (cycles >= cycleLimit) begin
         $display("Timeout: the program never reached its end address");
         timedOut = 1'b1;
      end else begin
         repeat (4) @(negedge clk);   // A few turns of the final loop
      end
      $display("Checks: %0d, errors: %0d, assertion failures: %0d",
               checks, errors, dut.props.assertFails);
      if (timedOut || errors != 0 || dut.props.assertFails != 0) begin
         $display("SOME TESTS FAILED");
      end else begin
         $display("ALL TESTS PASSED");
      end
      $finish;
   end

endmodule

/* all.f */
armPkg.sv
armAlu.sv
regFile.sv
armDecoder.sv
condUnit.sv
armDatapath.sv
armCore.sv
armCore_sva.sv
armCore_tb.sv
